/* rtl/i2c_chunk_pkg.sv */
/* I2C sequencer shared definitions
   Memory map, access slots, opcodes, bit commands and the memory write bus */
package i2c_chunk_pkg;

	localparam int tick_scale = 4;  // Tick every 2**tick_scale clocks
	localparam int bit_ticks = 14;  // Ticks in one bit period
	localparam int addr_w = 12;
	localparam int data_w = 8;

	// Quarters of the 4K memory
	localparam logic [addr_w-1:0] prog_base = 12'h000;  // Host-written program
	localparam logic [addr_w-1:0] spare_base = 12'h400;  // Plain memory
	localparam logic [addr_w-1:0] result_base = 12'h800;  // Completed results
	localparam logic [addr_w-1:0] pending_base = 12'hc00;  // Results in progress

	// Write port slots, even slots belong to the host
	localparam logic [3:0] slot_result = 4'd3;
	localparam logic [3:0] slot_fetch = 4'd5;  // Program address on the bus
	localparam logic [3:0] slot_latch = 4'd7;  // Program byte captured

	// Opcode in bits 7:5 of a program byte, argument n in bits 4:0
	localparam logic [2:0] op_end = 3'd0;
	localparam logic [2:0] op_write = 3'd1;  // Start, then n bytes from the program
	localparam logic [2:0] op_read = 3'd2;  // n bytes in, last one NACKed
	localparam logic [2:0] op_stop = 3'd3;
	localparam logic [2:0] op_flip = 3'd4;  // Swap result halves
	localparam logic [2:0] op_config = 3'd5;  // hw_config gets n[3:0]

	// A stop with sda_bit high means no command, the engine parks
	typedef enum logic [1:0] {
		bc_start = 2'd0,
		bc_stop = 2'd1,
		bc_send = 2'd2,
		bc_recv = 2'd3
	} bit_cmd_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
		logic stb;  // Write enable
	} xbus_t;

endpackage

/* rtl/i2c_slot_timer.sv */
/* Access slot timer
   Free-running counter giving the bit tick and the memory slot number */
`timescale 1ns/100ps
module i2c_slot_timer import i2c_chunk_pkg::*; (
	input clk,
	input reset,
	output logic tick,  // One clock wide, every 16 clocks
	output logic [3:0] slot  // Current write port slot
);

logic [tick_scale-1:0] access;  // Wraps on its own

always_ff @(posedge clk) begin
	if (reset) begin
		access <= '0;
		tick <= 1'b0;
	end else begin
		access <= access + 1'b1;
		tick <= &access;  // Lands while access reads 0
	end
end

assign slot = access[3:0];

endmodule

/* rtl/i2c_bit.sv */
/* I2C bit engine
   Plays one start, stop or data bit as SCL/SDA over 14 ticks */
`timescale 1ns/100ps
module i2c_bit import i2c_chunk_pkg::*; (
	input clk,
	input reset,
	input tick,
	input bit_cmd_t bit_cmd,
	input sda_bit,  // Level for a send bit
	output logic bit_adv,  // End of bit period
	output logic scl,
	output logic sda_drive,  // Low pulls SDA down
	output logic sda_h,  // SDA sampled during SCL high
	input sda_sense
);

localparam logic [3:0] last_phase = 4'(bit_ticks - 1);

logic [3:0] phase;  // Tick count within the bit
logic busy;  // Bus held between start and stop

// No command pending, wait at phase 0
wire hold = (bit_cmd == bc_stop) && sda_bit;
wire parked = hold && (phase == 4'd0);
wire step = tick && !parked;

always_ff @(posedge clk) begin
	if (reset) begin
		phase <= 4'd0;
		bit_adv <= 1'b0;
		scl <= 1'b1;  // Released bus
		sda_drive <= 1'b1;
		sda_h <= 1'b1;
		busy <= 1'b0;
	end else begin
		bit_adv <= 1'b0;
		if (step) begin
			phase <= (phase == last_phase) ? 4'd0 : phase + 4'd1;
			bit_adv <= (phase == last_phase);
			case (bit_cmd)
				bc_start: begin
					// Works from a free bus or as a repeated start
					if (phase == 4'd0) sda_drive <= 1'b1;
					if (phase == 4'd3) scl <= 1'b1;
					if (phase == 4'd7) begin
						sda_drive <= 1'b0;  // SDA falls, SCL high
						busy <= 1'b1;
					end
					if (phase == 4'd11) scl <= 1'b0;
				end
				bc_stop: begin
					if (phase == 4'd0 && busy) sda_drive <= 1'b0;  // SCL still low here
					if (phase == 4'd3) scl <= 1'b1;
					if (phase == 4'd7) begin
						sda_drive <= 1'b1;  // SDA rises, SCL high
						busy <= 1'b0;
					end
				end
				default: begin
					// Send and receive share one waveform
					if (phase == 4'd1) sda_drive <= (bit_cmd == bc_send) ? sda_bit : 1'b1;
					if (phase == 4'd4) scl <= 1'b1;
					if (phase == 4'd7) sda_h <= sda_sense;  // Middle of SCL high
					if (phase == 4'd11) scl <= 1'b0;
				end
			endcase
		end
	end
end

endmodule

/* rtl/i2c_prog.sv */
/* I2C command sequencer
   Fetches program bytes from memory and steps the bit engine through them */
`timescale 1ns/100ps
module i2c_prog import i2c_chunk_pkg::*; (
	input clk,
	input reset,
	input run_cmd,
	input bit_adv,
	input sda_h,
	input [3:0] slot,
	input [7:0] p_data,
	output logic [9:0] p_addr,
	output bit_cmd_t bit_cmd,
	output logic sda_bit,
	output logic [7:0] result,
	output logic result_stb,
	output logic [9:0] result_addr,
	output logic buffer_flip,
	output logic run_stat,
	output logic [3:0] hw_config
);

typedef enum logic [2:0] {st_idle, st_fetch, st_decode, st_shift, st_end} state_t;

state_t state;
logic fetch_armed;  // Our address went out at slot_fetch
logic fetch_data;  // Next fetch is a write byte, not an opcode
logic cond_wait;  // Start or stop in flight
logic rd_mode;
logic [4:0] byte_cnt;  // Bytes left in the current op
logic [3:0] bit_cnt;  // 0..7 data, 8 ack
logic [7:0] shifter;

wire [2:0] op = p_data[7:5];
wire [4:0] arg = p_data[4:0];
wire last_byte = (byte_cnt == 5'd1);

always_ff @(posedge clk) begin
	if (reset) begin
		state <= st_idle;
		p_addr <= '0;
		bit_cmd <= bc_stop;
		sda_bit <= 1'b1;  // Parks the bit engine
		result_stb <= 1'b0;
		result_addr <= '0;
		buffer_flip <= 1'b0;
		run_stat <= 1'b0;
		hw_config <= '0;
		fetch_armed <= 1'b0;
		fetch_data <= 1'b0;
		cond_wait <= 1'b0;
		rd_mode <= 1'b0;
		byte_cnt <= '0;
		bit_cnt <= '0;
	end else begin
		result_stb <= 1'b0;
		buffer_flip <= 1'b0;
		if (result_stb) result_addr <= result_addr + 1'b1;  // Next result slot
		case (state)
			st_idle: if (run_cmd) begin
				run_stat <= 1'b1;
				p_addr <= '0;
				result_addr <= '0;
				fetch_data <= 1'b0;
				state <= st_fetch;
			end
			st_fetch: begin
				if (slot == slot_fetch) fetch_armed <= 1'b1;
				if (fetch_armed && slot == slot_latch) begin  // p_data valid next cycle
					fetch_armed <= 1'b0;
					p_addr <= p_addr + 1'b1;
					state <= st_decode;
				end
			end
			st_decode: begin
				if (fetch_data) begin
					shifter <= p_data;  // Byte to send, MSB first
					bit_cnt <= '0;
					bit_cmd <= bc_send;
					sda_bit <= p_data[7];
					state <= st_shift;
				end else if (cond_wait) begin
					if (bit_adv) begin
						cond_wait <= 1'b0;
						bit_cmd <= bc_stop;
						sda_bit <= 1'b1;
						fetch_data <= (byte_cnt != 5'd0);  // Write bytes follow a start
						state <= st_fetch;
					end
				end else begin
					case (op)
						op_end: state <= st_end;
						op_write: begin
							bit_cmd <= bc_start;
							sda_bit <= 1'b0;
							byte_cnt <= arg;
							rd_mode <= 1'b0;
							cond_wait <= 1'b1;
						end
						op_read: begin
							if (arg != 5'd0) begin
								byte_cnt <= arg;
								rd_mode <= 1'b1;
								bit_cnt <= '0;
								bit_cmd <= bc_recv;
								sda_bit <= 1'b1;
								state <= st_shift;
							end else begin
								state <= st_fetch;
							end
						end
						op_stop: begin
							bit_cmd <= bc_stop;
							sda_bit <= 1'b0;  // Real stop
							byte_cnt <= '0;
							cond_wait <= 1'b1;
						end
						op_flip: begin
							buffer_flip <= 1'b1;
							result_addr <= '0;
							state <= st_fetch;
						end
						op_config: begin
							hw_config <= arg[3:0];
							state <= st_fetch;
						end
						default: state <= st_fetch;  // Unused opcodes skip
					endcase
				end
			end
			st_shift: if (bit_adv) begin
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt < 4'd7) begin
					shifter <= {shifter[6:0], sda_h};
					bit_cmd <= rd_mode ? bc_recv : bc_send;
					sda_bit <= rd_mode ? 1'b1 : shifter[6];
				end else if (bit_cnt == 4'd7) begin
					if (rd_mode) begin
						result <= {shifter[6:0], sda_h};
						result_stb <= 1'b1;
						bit_cmd <= bc_send;
						sda_bit <= last_byte;  // NACK the final byte
					end else begin
						bit_cmd <= bc_recv;  // Slave ack
						sda_bit <= 1'b1;
					end
				end else begin
					bit_cnt <= '0;
					byte_cnt <= byte_cnt - 1'b1;
					if (rd_mode && !last_byte) begin
						bit_cmd <= bc_recv;
						sda_bit <= 1'b1;
					end else begin
						bit_cmd <= bc_stop;
						sda_bit <= 1'b1;
						fetch_data <= !rd_mode && !last_byte;
						state <= st_fetch;
					end
				end
			end
			st_end: begin
				run_stat <= 1'b0;
				state <= st_idle;
			end
			default: state <= st_idle;
		endcase
	end
end

endmodule

/* rtl/i2c_xbus_mux.sv */
/* Memory write port collator
   Slots host, result and fetch traffic and keeps the ping-pong result buffer */
`timescale 1ns/100ps
module i2c_xbus_mux import i2c_chunk_pkg::*; (
	input clk,
	input reset,
	input [3:0] slot,
	input [addr_w-1:0] lb_addr,
	input [data_w-1:0] lb_din,
	input lb_write,
	input [9:0] p_addr,
	input [7:0] result,
	input result_stb,
	input [9:0] result_addr,
	input buffer_flip,
	input freeze,
	input [7:0] xbo,  // Port A read data
	output xbus_t xbus,
	output logic [7:0] p_data,
	output logic [addr_w-1:0] lb_addr_mem,
	output logic updated,
	output logic err_flag
);

logic [addr_w-1:0] lb_wbufa;
logic [data_w-1:0] lb_wbufd;
logic lb_wpend;
logic [addr_w-1:0] res_addr;
logic [data_w-1:0] res_data;
logic res_pend;
logic pingpong;  // Which upper quarter is being filled
logic freeze_r, freeze_d;

// Host sees the finished half at 0x800
wire lb_flip = lb_addr[11] & ~pingpong;
wire [addr_w-1:0] lb_swap = lb_addr ^ {1'b0, lb_flip, 10'b0};

always_ff @(posedge clk) begin
	lb_addr_mem <= lb_swap;  // Second cycle of host read latency
	if (slot == slot_latch) p_data <= xbo;  // Two cycles after slot_fetch
	if (lb_write) begin
		lb_wbufa <= lb_swap;
		lb_wbufd <= lb_din;
	end
	if (result_stb) begin
		res_addr <= (pingpong ? pending_base : result_base) | addr_w'(result_addr);
		res_data <= result;
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		xbus <= '0;
		lb_wpend <= 1'b0;
		res_pend <= 1'b0;
		err_flag <= 1'b0;
		pingpong <= 1'b0;
		freeze_r <= 1'b0;
		freeze_d <= 1'b0;
		updated <= 1'b0;
	end else begin
		freeze_r <= freeze;  // Freeze may come from elsewhere
		freeze_d <= freeze_r;
		casez (slot)
			4'b???0: begin
				xbus <= '{addr: lb_wbufa, data: lb_wbufd, stb: lb_wpend};
				lb_wpend <= 1'b0;
			end
			slot_result: begin
				xbus <= '{addr: res_addr, data: res_data, stb: res_pend};
				res_pend <= 1'b0;
			end
			slot_fetch: begin
				xbus.addr <= prog_base | addr_w'(p_addr);  // Read only
				xbus.stb <= 1'b0;
			end
			default: xbus.stb <= 1'b0;
		endcase
		if (lb_write) begin
			lb_wpend <= 1'b1;
			if (lb_wpend) err_flag <= 1'b1;  // Sticky, older write lost
		end
		if (result_stb) res_pend <= 1'b1;
		// Flip only outside a freeze
		if (buffer_flip && !freeze_d) begin
			pingpong <= ~pingpong;
			updated <= 1'b1;
		end
		if (!freeze_r && freeze_d) updated <= 1'b0;  // Freeze released
	end
end

endmodule

/* rtl/i2c_dpram.sv */
/* 4K x 8 dual-port RAM
   Port A writes from the collated bus and reads for fetch, port B serves the host */
`timescale 1ns/100ps
module i2c_dpram import i2c_chunk_pkg::*; (
	input clk,
	input xbus_t xbus,
	output logic [data_w-1:0] douta,
	input [addr_w-1:0] addrb,
	output logic [data_w-1:0] doutb
);

logic [data_w-1:0] mem [0:(1 << addr_w) - 1];

always_ff @(posedge clk) begin
	if (xbus.stb) mem[xbus.addr] <= xbus.data;
	douta <= mem[xbus.addr];  // Old data on a write
	doutb <= mem[addrb];
end

endmodule

/* rtl/i2c_chunk.sv */
/* I2C command sequencer top
   Host-programmed I2C engine sharing one memory with the local bus */
`timescale 1ns/100ps
module i2c_chunk import i2c_chunk_pkg::*; (
	input clk,
	input reset,
	input [addr_w-1:0] lb_addr,
	input [data_w-1:0] lb_din,
	input lb_write,
	output [data_w-1:0] lb_dout,  // Two cycles after lb_addr
	input run_cmd,
	input freeze,
	output run_stat,
	output updated,
	output err_flag,
	output [3:0] hw_config,  // Bus select for the board
	output scl,
	output sda_drive,
	input sda_sense
);

logic tick;
logic [3:0] slot;
logic bit_adv, sda_h, sda_bit;
bit_cmd_t bit_cmd;
logic [9:0] p_addr, result_addr;
logic [7:0] p_data, result, xbo;
logic result_stb, buffer_flip;
xbus_t xbus;
logic [addr_w-1:0] lb_addr_mem;

i2c_slot_timer u_timer (.clk(clk), .reset(reset), .tick(tick), .slot(slot));

i2c_prog u_prog (
	.clk(clk), .reset(reset), .run_cmd(run_cmd), .bit_adv(bit_adv), .sda_h(sda_h),
	.slot(slot), .p_data(p_data), .p_addr(p_addr), .bit_cmd(bit_cmd), .sda_bit(sda_bit),
	.result(result), .result_stb(result_stb), .result_addr(result_addr),
	.buffer_flip(buffer_flip), .run_stat(run_stat), .hw_config(hw_config)
);

i2c_bit u_bit (
	.clk(clk), .reset(reset), .tick(tick), .bit_cmd(bit_cmd), .sda_bit(sda_bit),
	.bit_adv(bit_adv), .scl(scl), .sda_drive(sda_drive), .sda_h(sda_h),
	.sda_sense(sda_sense)
);

i2c_xbus_mux u_mux (
	.clk(clk), .reset(reset), .slot(slot), .lb_addr(lb_addr), .lb_din(lb_din),
	.lb_write(lb_write), .p_addr(p_addr), .result(result), .result_stb(result_stb),
	.result_addr(result_addr), .buffer_flip(buffer_flip), .freeze(freeze), .xbo(xbo),
	.xbus(xbus), .p_data(p_data), .lb_addr_mem(lb_addr_mem), .updated(updated),
	.err_flag(err_flag)
);

i2c_dpram u_ram (
	.clk(clk), .xbus(xbus), .douta(xbo), .addrb(lb_addr_mem), .doutb(lb_dout)
);

endmodule

/* testbench/i2c_chunk_assertions.sv */
/* Bit engine protocol checks
   Bound into the I2C bit engine */
`timescale 1ns/100ps
module i2c_chunk_assertions import i2c_chunk_pkg::*; (
	input clk,
	input reset,
	input bit_cmd_t bit_cmd,
	input sda_bit,
	input bit_adv,
	input scl,
	input sda_drive,
	input [3:0] phase,
	input busy
);

// End of bit period is a single pulse
adv_one_cycle: assert property (@(posedge clk) disable iff (reset)
	bit_adv |=> !bit_adv)
	else $error("bit_adv high for more than one cycle");

// SDA may only move under a high SCL for start and stop
sda_stable_scl_high: assert property (@(posedge clk) disable iff (reset)
	(scl && $past(scl) && sda_drive != $past(sda_drive)) |->
	($past(bit_cmd) == bc_start || $past(bit_cmd) == bc_stop))
	else $error("sda_drive changed with scl high outside start or stop");

// Parked with a free bus
idle_scl_high: assert property (@(posedge clk) disable iff (reset)
	(bit_cmd == bc_stop && sda_bit && phase == 4'd0 && !busy) |-> scl)
	else $error("scl low while the bit engine is idle");

endmodule

bind i2c_bit i2c_chunk_assertions u_protocol (
	.clk(clk), .reset(reset), .bit_cmd(bit_cmd), .sda_bit(sda_bit), .bit_adv(bit_adv),
	.scl(scl), .sda_drive(sda_drive), .phase(phase), .busy(busy)
);

/* testbench/i2c_chunk_tb.sv */
/* I2C sequencer testbench
   Host bus driver, I2C slave model and result checks from a test file */
`timescale 1ns/100ps
module i2c_chunk_tb import i2c_chunk_pkg::*; ();

logic clk, reset;
logic [addr_w-1:0] lb_addr;
logic [data_w-1:0] lb_din;
logic lb_write, run_cmd, freeze;
wire [data_w-1:0] lb_dout;
wire run_stat, updated, err_flag, scl, sda_drive, sda_sense;
wire [3:0] hw_config;
logic slave_sda;  // Open drain where low pulls the line

logic [7:0] tests [0:26];
logic [7:0] prog_b [0:1][0:31];
logic [7:0] rdat [0:1][0:31];
int plen [0:1];
int nrd [0:1];
logic [3:0] cfg [0:1];
int unsigned cycles = 0;
int unsigned limit = 2000;
int seed = 32'h2d80f2ac;

// Slave model state
int sl_bits;  // Clocks seen in this byte with the 9th as ack
logic sl_first, sl_read, sl_txing, scl_q, sda_q;
logic [7:0] sl_shift, sl_tx;
logic [7:0] wr_seen [$];  // Bytes the master wrote
logic acks [$];  // Master ack bits after read bytes
logic [7:0] rd_q [$];

assign sda_sense = sda_drive & slave_sda;  // Wired AND bus

i2c_chunk i_dut (
	.clk(clk), .reset(reset), .lb_addr(lb_addr), .lb_din(lb_din), .lb_write(lb_write),
	.lb_dout(lb_dout), .run_cmd(run_cmd), .freeze(freeze), .run_stat(run_stat),
	.updated(updated), .err_flag(err_flag), .hw_config(hw_config), .scl(scl),
	.sda_drive(sda_drive), .sda_sense(sda_sense)
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

task automatic abort_run();
	$display("Some tests failed");
	$fatal(1, "Stopped at the first failure");
endtask

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles >= limit) begin
		$display("Timeout, run exceeded %0d cycles", limit);
		abort_run();
	end
end

// Slave sees SCL rise and fall on the next falling clock and answers there
always @(negedge clk) begin
	if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda_sense === 1'b0) begin
		sl_bits = 0;  // Start
		sl_first = 1'b1;
		sl_read = 1'b0;
		sl_txing = 1'b0;
	end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda_sense === 1'b1) begin
		sl_bits = 0;  // Stop
		sl_read = 1'b0;
		sl_txing = 1'b0;
		slave_sda = 1'b1;
	end else if (scl === 1'b1 && scl_q === 1'b0) begin
		if (sl_bits < 8) sl_shift = {sl_shift[6:0], sda_sense};
		else if (sl_txing) acks.push_back(sda_sense);
		sl_bits++;
	end else if (scl === 1'b0 && scl_q === 1'b1) begin
		if (sl_bits == 8) begin
			if (sl_txing) begin
				slave_sda = 1'b1;  // Master acks
			end else begin
				wr_seen.push_back(sl_shift);
				if (sl_first) sl_read = sl_shift[0];  // R/W bit of the address
				sl_first = 1'b0;
				slave_sda = 1'b0;  // Ack
			end
		end else if (sl_bits == 9) begin
			sl_bits = 0;
			if (sl_read && (!sl_txing || !acks[acks.size() - 1]) && rd_q.size() > 0) begin
				sl_tx = rd_q.pop_front();
				sl_txing = 1'b1;
				slave_sda = sl_tx[7];  // MSB first
			end else begin
				sl_txing = 1'b0;
				slave_sda = 1'b1;
			end
		end else if (sl_txing && sl_bits > 0) begin
			sl_tx = sl_tx << 1;
			slave_sda = sl_tx[7];
		end
	end
	scl_q = scl;
	sda_q = sda_sense;
end

task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
	assert (got === exp) else begin
		$display("** Error: %s = %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic host_write(input logic [addr_w-1:0] addr, input logic [7:0] data);
	@(negedge clk);
	lb_addr = addr;
	lb_din = data;
	lb_write = 1'b1;
	@(negedge clk) lb_write = 1'b0;
	repeat (2) @(negedge clk);  // Let the even slot commit it
endtask

task automatic host_read(input logic [addr_w-1:0] addr, output logic [7:0] data);
	@(negedge clk) lb_addr = addr;
	repeat (2) @(negedge clk);
	data = lb_dout;
endtask

function automatic int prog_bits(input int t);
	int bits;
	int i;
	int n;
	bits = 0;
	i = 0;
	while (i < plen[t]) begin
		n = int'(prog_b[t][i][4:0]);
		case (prog_b[t][i][7:5])
			op_write: begin
				bits = bits + 1 + 9 * n;  // Start plus bytes with ack
				i = i + n;
			end
			op_read: bits = bits + 9 * n;
			op_stop: bits = bits + 1;
			default: ;
		endcase
		i++;
	end
	return bits;
endfunction

task automatic load_program(input int t);
	int i;
	for (i = 0; i < plen[t]; i++) host_write(prog_base + 12'(i), prog_b[t][i]);
endtask

task automatic run_program(input int t);
	int i;
	int waited;
	wr_seen.delete();
	acks.delete();
	rd_q.delete();
	for (i = 0; i < nrd[t]; i++) rd_q.push_back(rdat[t][i]);
	@(negedge clk) run_cmd = 1'b1;
	@(negedge clk) run_cmd = 1'b0;
	waited = 1;
	while (!run_stat && waited < 2) begin
		@(negedge clk);
		waited++;
	end
	assert (run_stat) else begin
		$display("run_stat did not rise within 2 cycles of run_cmd");
		abort_run();
	end
	while (run_stat) @(negedge clk);
endtask

// Written bytes against the program and acks against the read count
task automatic check_bus(input int t);
	int i;
	int k;
	int n;
	int w;
	w = 0;
	i = 0;
	while (i < plen[t]) begin
		n = int'(prog_b[t][i][4:0]);
		if (prog_b[t][i][7:5] == op_write) begin
			for (k = 1; k <= n; k++) begin
				assert (w < wr_seen.size()) else begin
					$display("Slave saw fewer written bytes than the program sends");
					abort_run();
				end
				check_value("wr_seen", wr_seen[w], prog_b[t][i + k]);
				w++;
			end
			i = i + n;
		end
		i++;
	end
	assert (w == wr_seen.size()) else begin
		$display("Slave saw more written bytes than the program sends");
		abort_run();
	end
	assert (acks.size() == nrd[t]) else begin
		$display("Number of master ack bits differs from the read count");
		abort_run();
	end
	for (k = 0; k < nrd[t]; k++) check_value("acks", 8'(acks[k]), 8'(k == nrd[t] - 1));
endtask

task automatic check_results(input int t);
	int i;
	logic [7:0] d;
	for (i = 0; i < nrd[t]; i++) begin
		host_read(result_base + 12'(i), d);
		check_value("lb_dout", d, rdat[t][i]);
	end
endtask

initial begin
	int p;
	int t;
	int i;
	logic [addr_w-1:0] probe [0:3];
	logic [7:0] pdata [0:3];
	logic [7:0] d;
	lb_addr = '0;
	lb_din = '0;
	lb_write = 1'b0;
	run_cmd = 1'b0;
	freeze = 1'b0;
	slave_sda = 1'b1;
	reset = 1'b1;
	sl_bits = 0;
	sl_first = 1'b0;
	sl_read = 1'b0;
	sl_txing = 1'b0;
	$readmemh("testbench/i2c_chunk_tests.txt", tests);
	p = 0;
	for (t = 0; t < 2; t++) begin
		plen[t] = int'(tests[p]);
		for (i = 0; i < plen[t]; i++) prog_b[t][i] = tests[p + 1 + i];
		p = p + plen[t] + 1;
		nrd[t] = int'(tests[p]);
		for (i = 0; i < nrd[t]; i++) rdat[t][i] = tests[p + 1 + i];
		p = p + nrd[t] + 1;
		cfg[t] = tests[p][3:0];
		p++;
	end
	limit = 2 * 224 * (prog_bits(0) + 2 * prog_bits(1)) + 2000;  // Program 1 runs twice
	repeat (2) @(posedge clk);
	@(negedge clk) reset = 1'b0;

	check_value("run_stat", 8'(run_stat), 8'h0);
	check_value("updated", 8'(updated), 8'h0);
	check_value("err_flag", 8'(err_flag), 8'h0);
	check_value("scl", 8'(scl), 8'h1);
	check_value("sda_drive", 8'(sda_drive), 8'h1);

	// One address in every quarter
	probe = '{12'h010, 12'h400, 12'h8f0, 12'hcf0};
	for (i = 0; i < 4; i++) begin
		pdata[i] = 8'($random(seed));
		host_write(probe[i], pdata[i]);
	end
	for (i = 0; i < 4; i++) begin
		host_read(probe[i], d);
		check_value("lb_dout", d, pdata[i]);
	end

	load_program(0);
	run_program(0);
	check_value("hw_config", 8'(hw_config), 8'(cfg[0]));
	check_value("updated", 8'(updated), 8'h1);
	check_bus(0);
	check_results(0);

	// Flip under freeze is dropped
	@(negedge clk) freeze = 1'b1;
	repeat (3) @(negedge clk);
	load_program(1);
	run_program(1);
	check_bus(1);
	check_value("hw_config", 8'(hw_config), 8'(cfg[1]));
	check_value("updated", 8'(updated), 8'h1);
	check_results(0);
	@(negedge clk) freeze = 1'b0;
	repeat (4) @(negedge clk);
	check_value("updated", 8'(updated), 8'h0);
	run_program(1);
	check_bus(1);
	check_value("updated", 8'(updated), 8'h1);
	check_results(1);

	check_value("err_flag", 8'(err_flag), 8'h0);
	@(negedge clk);
	lb_addr = spare_base + 12'h020;
	lb_din = 8'($random(seed));
	lb_write = 1'b1;
	@(negedge clk) lb_din = 8'($random(seed));
	@(negedge clk) lb_write = 1'b0;
	repeat (3) @(negedge clk);
	check_value("err_flag", 8'(err_flag), 8'h1);
	repeat (20) @(negedge clk);
	check_value("err_flag", 8'(err_flag), 8'h1);  // Sticky

	$display("All tests passed");
	$finish;
end

endmodule

/* testbench/i2c_chunk_tests.txt */
// Per test: program length, program bytes, slave read count, slave read bytes, hw_config
// Ops: a5 config 5, 21 write 1, a1 address byte, 43 read 3, 60 stop, 80 flip, 00 end
07
a5 21 a1 43 60 80 00
03
5a c3 0f
05
// Second program, run under freeze and again after it
07
aa 21 91 44 60 80 00
04
3c 96 e1 7e
0a

/* i2c_chunk.f */
rtl/i2c_chunk_pkg.sv
rtl/i2c_slot_timer.sv
rtl/i2c_bit.sv
rtl/i2c_prog.sv
rtl/i2c_xbus_mux.sv
rtl/i2c_dpram.sv
rtl/i2c_chunk.sv
testbench/i2c_chunk_assertions.sv
testbench/i2c_chunk_tb.sv

/* Makefile */
# Verilator build and run for the I2C sequencer testbench
VERILATOR ?= verilator
TOP ?= i2c_chunk_tb
RTL_TOP ?= i2c_chunk
FILELIST ?= i2c_chunk.f
OBJ_DIR ?= obj_dir
PASS_MSG ?= All tests passed
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
